// File: Makefile
# Verilator flow for the LCD subsystem testbench
TOP = lcd_tb
LOG = sim.log

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): sim.f hw/*.sv test/*.sv
	verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
		--top-module $(TOP) -f sim.f

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+100 2>&1 | tee $(LOG)
	@if grep -q "Errors found" $(LOG); then \
		echo "FAIL: see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "No errors" $(LOG) || { echo "FAIL: run did not complete"; exit 1; }
	@echo "PASS"

clean:
	rm -rf obj_dir $(LOG)

// File: hw/lcd_apb_regs.sv
module lcd_apb_regs #(
	parameter int FIFO_DEPTH = 8
) (
	input logic clk,
	input logic rst_n,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input lcd_pkg::apb_addr_t paddr,
	input lcd_pkg::apb_data_t pwdata,
	input logic full,
	input logic [$clog2(FIFO_DEPTH + 1)-1:0] level,
	input logic busy,
	input logic init_done,
	output lcd_pkg::apb_data_t prdata,
	output logic pready,
	output logic pslverr,
	output lcd_pkg::lcd_cfg_t cfg,
	output logic init_start,
	output logic push,
	output lcd_pkg::lcd_cmd_t cmd_in
);
	import lcd_pkg::*;

	localparam int LW = $clog2(FIFO_DEPTH + 1);

	logic access;
	logic wr;
	logic rd;
	logic hit_ctrl;
	logic hit_cmd;
	logic hit_status;
	logic mapped;
	logic cmd_drop;
	logic overflow;
	apb_data_t status;

	assign access = psel & penable;		// access phase only
	assign wr = access & pwrite;
	assign rd = access & ~pwrite;

	assign hit_ctrl = (paddr == REG_CTRL);
	assign hit_cmd = (paddr == REG_CMD);
	assign hit_status = (paddr == REG_STATUS);
	assign mapped = hit_ctrl | hit_cmd | hit_status;

	assign cmd_drop = wr & hit_cmd & full;	// push into a full fifo

	assign pready = 1'b1;			// no wait states
	assign pslverr = access & (~mapped | cmd_drop);

	// fifo write happens on the edge closing the access
	assign push = wr & hit_cmd & ~full;
	assign cmd_in = '{rs: pwdata[CMD_RS_BIT], data: pwdata[7:0]};

	always_comb begin
		status = '0;
		status[ST_BUSY_BIT] = busy;
		status[ST_INIT_DONE_BIT] = init_done;
		status[ST_OVERFLOW_BIT] = overflow;
		status[ST_LEVEL_LSB +: LW] = level;
	end

	always_comb begin
		prdata = '0;
		if (rd) begin
			case (paddr)
				REG_CTRL: prdata = apb_data_t'(cfg);
				REG_STATUS: prdata = status;
				default: prdata = '0;	// cmd reads as zero
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cfg <= '0;
			init_start <= 1'b0;
			overflow <= 1'b0;
		end else begin
			init_start <= wr & hit_ctrl & pwdata[CTRL_START_BIT];	// one cycle
			if (wr && hit_ctrl)
				cfg <= pwdata[6:0];
			if (cmd_drop)
				overflow <= 1'b1;	// sticky
			else if (wr && hit_status)
				overflow <= 1'b0;
		end
	end

endmodule

// File: hw/lcd_bus_ctrl.sv
module lcd_bus_ctrl #(
	parameter int CLK_PER_US = 40
) (
	input logic clk,
	input logic rst_n,
	input lcd_pkg::lcd_cfg_t cfg,
	input logic init_start,
	input logic cmd_valid,
	input lcd_pkg::lcd_cmd_t cmd_out,
	output logic cmd_ready,
	output logic init_done,
	output logic busy,
	output logic e,
	output logic rs,
	output lcd_pkg::lcd_byte_t lcd_data
);
	import lcd_pkg::*;

	function automatic int unsigned umax(input int unsigned a, input int unsigned b);
		return (a > b) ? a : b;
	endfunction

	// delays in clock cycles
	localparam int unsigned PWRUP_CYC = PWRUP_US * CLK_PER_US;
	localparam int unsigned PULSE_CYC = INIT_PULSE_US * CLK_PER_US;
	localparam int unsigned FSET_CYC = (INIT_PULSE_US + FSET_WAIT_US) * CLK_PER_US;
	localparam int unsigned DISP_CYC = (INIT_PULSE_US + DISP_WAIT_US) * CLK_PER_US;
	localparam int unsigned CLEAR_CYC = (INIT_PULSE_US + CLEAR_WAIT_US) * CLK_PER_US;
	localparam int unsigned ENTRY_CYC = (INIT_PULSE_US + ENTRY_WAIT_US) * CLK_PER_US;
	localparam int unsigned SETUP_CYC = SETUP_US * CLK_PER_US;
	localparam int unsigned EHIGH_CYC = E_HIGH_US * CLK_PER_US;
	// never shorter than setup + high + low
	localparam int unsigned CYCLE_CYC =
		umax(CYCLE_US, SETUP_US + E_HIGH_US + E_LOW_US) * CLK_PER_US;

	localparam int unsigned MAX_CYC = umax(umax(umax(PWRUP_CYC, FSET_CYC),
		umax(DISP_CYC, CLEAR_CYC)), umax(ENTRY_CYC, CYCLE_CYC));
	localparam int CW = $clog2(MAX_CYC + 1);

	typedef logic [CW-1:0] cnt_t;

	typedef enum logic [2:0] {
		ST_PWRUP,
		ST_WAIT_START,
		ST_INIT,
		ST_IDLE,
		ST_WRITE
	} state_t;

	state_t state;
	cnt_t cnt;
	logic [1:0] init_step;		// fset, disp, clear, entry
	logic start_pend;

	// instruction byte for each init step
	function automatic lcd_byte_t init_instr(input logic [1:0] idx, input lcd_cfg_t c);
		case (idx)
			2'd0: return {4'b0011, c[6], c[5], 2'b00};	// function set
			2'd1: return {5'b00001, c[4], c[3], c[2]};	// display on/off
			2'd2: return 8'b0000_0001;			// clear
			default: return {6'b000001, c[1], c[0]};	// entry mode
		endcase
	endfunction

	// last count of each step, pulse plus its wait
	function automatic cnt_t step_last(input logic [1:0] idx);
		case (idx)
			2'd0: return cnt_t'(FSET_CYC - 1);
			2'd1: return cnt_t'(DISP_CYC - 1);
			2'd2: return cnt_t'(CLEAR_CYC - 1);
			default: return cnt_t'(ENTRY_CYC - 1);
		endcase
	endfunction

	assign cmd_ready = (state == ST_IDLE) & cmd_valid;
	assign busy = (state != ST_IDLE) | cmd_valid;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_PWRUP;
			cnt <= '0;
			init_step <= '0;
			start_pend <= 1'b0;
			init_done <= 1'b0;
			e <= 1'b0;
			rs <= 1'b0;
			lcd_data <= '0;
		end else begin
			if (init_start && state == ST_PWRUP)
				start_pend <= 1'b1;		// early start, keep it
			case (state)
				ST_PWRUP: begin
					if (cnt == cnt_t'(PWRUP_CYC - 1)) begin
						cnt <= '0;
						state <= ST_WAIT_START;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				ST_WAIT_START: begin
					if (start_pend || init_start) begin
						start_pend <= 1'b0;
						state <= ST_INIT;
						init_step <= 2'd0;
						cnt <= '0;
						e <= 1'b1;		// first pulse starts now
						rs <= 1'b0;
						lcd_data <= init_instr(2'd0, cfg);
					end
				end
				ST_INIT: begin
					if (cnt == cnt_t'(PULSE_CYC - 1))
						e <= 1'b0;
					if (cnt == step_last(init_step)) begin
						cnt <= '0;
						if (init_step == 2'd3) begin
							state <= ST_IDLE;
							init_done <= 1'b1;
						end else begin
							init_step <= init_step + 1'b1;
							e <= 1'b1;
							lcd_data <= init_instr(init_step + 2'd1, cfg);
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				ST_IDLE: begin
					if (cmd_valid) begin
						state <= ST_WRITE;
						cnt <= '0;
						rs <= cmd_out.rs;	// held for whole cycle
						lcd_data <= cmd_out.data;
					end
				end
				ST_WRITE: begin
					if (cnt == cnt_t'(SETUP_CYC - 1))
						e <= 1'b1;
					if (cnt == cnt_t'(SETUP_CYC + EHIGH_CYC - 1))
						e <= 1'b0;
					if (cnt == cnt_t'(CYCLE_CYC - 1)) begin
						cnt <= '0;
						state <= ST_IDLE;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: begin
					state <= ST_PWRUP;
					cnt <= '0;
					e <= 1'b0;
				end
			endcase
		end
	end

endmodule

// File: hw/lcd_cmd_fifo.sv
module lcd_cmd_fifo #(
	parameter int FIFO_DEPTH = 8
) (
	input logic clk,
	input logic rst_n,
	input logic push,
	input lcd_pkg::lcd_cmd_t cmd_in,
	input logic cmd_ready,
	output logic cmd_valid,
	output lcd_pkg::lcd_cmd_t cmd_out,
	output logic full,
	output logic [$clog2(FIFO_DEPTH + 1)-1:0] level
);
	import lcd_pkg::*;

	localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int LW = $clog2(FIFO_DEPTH + 1);

	typedef logic [PW-1:0] ptr_t;

	lcd_cmd_t mem [FIFO_DEPTH];
	ptr_t wr_ptr;
	ptr_t rd_ptr;
	logic [LW-1:0] count;
	logic do_push;
	logic do_pop;

	// wrap at depth, works for any depth
	function automatic ptr_t ptr_inc(input ptr_t p);
		return (p == ptr_t'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign do_push = push & ~full;
	assign do_pop = cmd_ready & cmd_valid;

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= cmd_in;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;	// both or neither
			endcase
		end
	end

	assign cmd_valid = (count != '0);
	assign cmd_out = mem[rd_ptr];		// head entry
	assign full = (count == LW'(FIFO_DEPTH));
	assign level = count;

endmodule

// File: hw/lcd_pkg.sv
package lcd_pkg;

	typedef logic [7:0] lcd_byte_t;		// instruction or data byte
	typedef logic [6:0] lcd_cfg_t;		// {lines, font, disp, cursor, blink, inc, shift}
	typedef logic [3:0] apb_addr_t;		// register offset
	typedef logic [31:0] apb_data_t;

	typedef struct packed {
		logic rs;			// 1 = data, 0 = instruction
		lcd_byte_t data;
	} lcd_cmd_t;

	// register map
	localparam apb_addr_t REG_CTRL = 4'h0;
	localparam apb_addr_t REG_CMD = 4'h4;
	localparam apb_addr_t REG_STATUS = 4'h8;

	localparam int CTRL_START_BIT = 8;	// write 1 to kick off init
	localparam int CMD_RS_BIT = 8;		// rs above the data byte

	localparam int ST_BUSY_BIT = 0;
	localparam int ST_INIT_DONE_BIT = 1;
	localparam int ST_OVERFLOW_BIT = 2;
	localparam int ST_LEVEL_LSB = 8;	// fifo level in 11:8

	// power-up and init timing in us
	localparam int unsigned PWRUP_US = 500;
	localparam int unsigned INIT_PULSE_US = 10;
	localparam int unsigned FSET_WAIT_US = 50;
	localparam int unsigned DISP_WAIT_US = 50;
	localparam int unsigned CLEAR_WAIT_US = 200;
	localparam int unsigned ENTRY_WAIT_US = 100;

	// single write cycle in us
	localparam int unsigned SETUP_US = 1;
	localparam int unsigned E_HIGH_US = 13;
	localparam int unsigned E_LOW_US = 13;
	localparam int unsigned CYCLE_US = 50;

endpackage

// File: hw/lcd_subsys_top.sv
module lcd_subsys_top #(
	parameter int CLK_PER_US = 40,
	parameter int FIFO_DEPTH = 8
) (
	input logic clk,
	input logic rst_n,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input lcd_pkg::apb_addr_t paddr,
	input lcd_pkg::apb_data_t pwdata,
	output lcd_pkg::apb_data_t prdata,
	output logic pready,
	output logic pslverr,
	output logic e,
	output logic rs,
	output lcd_pkg::lcd_byte_t lcd_data
);
	import lcd_pkg::*;

	localparam int LW = $clog2(FIFO_DEPTH + 1);

	lcd_cfg_t cfg;
	lcd_cmd_t cmd_in;
	lcd_cmd_t cmd_out;
	logic init_start;
	logic push;
	logic full;
	logic [LW-1:0] level;
	logic cmd_valid;
	logic cmd_ready;
	logic init_done;
	logic busy;

	lcd_apb_regs #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_regs (
		.clk(clk),
		.rst_n(rst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.full(full),
		.level(level),
		.busy(busy),
		.init_done(init_done),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.cfg(cfg),
		.init_start(init_start),
		.push(push),
		.cmd_in(cmd_in)
	);

	lcd_cmd_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.push(push),
		.cmd_in(cmd_in),
		.cmd_ready(cmd_ready),
		.cmd_valid(cmd_valid),
		.cmd_out(cmd_out),
		.full(full),
		.level(level)
	);

	lcd_bus_ctrl #(
		.CLK_PER_US(CLK_PER_US)
	) u_bus (
		.clk(clk),
		.rst_n(rst_n),
		.cfg(cfg),
		.init_start(init_start),
		.cmd_valid(cmd_valid),
		.cmd_out(cmd_out),
		.cmd_ready(cmd_ready),
		.init_done(init_done),
		.busy(busy),
		.e(e),
		.rs(rs),
		.lcd_data(lcd_data)
	);

endmodule

// File: sim.f
hw/lcd_pkg.sv
hw/lcd_cmd_fifo.sv
hw/lcd_apb_regs.sv
hw/lcd_bus_ctrl.sv
hw/lcd_subsys_top.sv
test/lcd_bus_checker.sv
test/lcd_tb.sv

// File: test/lcd_bus_checker.sv
module lcd_bus_checker (
	input logic clk,
	input logic rst_n,
	input logic e,
	input logic rs,
	input lcd_pkg::lcd_byte_t lcd_data,
	input logic quiet_state,
	input logic cmd_ready,
	input logic cmd_valid,
	input logic init_done
);
	timeunit 1ns;
	timeprecision 100ps;

	int assert_fails = 0;		// count of failed assertions

	// the display latches on the falling edge, so the bus must hold
	bus_stable_while_e: assert property (@(posedge clk) disable iff (!rst_n)
		(e && $past(e)) |-> ($stable(rs) && $stable(lcd_data)))
	else begin
		assert_fails++;
		$error("rs or lcd_data changed while e was high");
	end

	e_low_when_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		quiet_state |-> !e)
	else begin
		assert_fails++;
		$error("e high in wait-start or idle state");
	end

	// an entry is taken in a single cycle, and only after init
	ready_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
		cmd_ready |-> (cmd_valid && init_done) ##1 !cmd_ready)
	else begin
		assert_fails++;
		$error("cmd_ready without cmd_valid, before init or held past one cycle");
	end

endmodule

bind lcd_bus_ctrl lcd_bus_checker bus_chk (
	.clk(clk),
	.rst_n(rst_n),
	.e(e),
	.rs(rs),
	.lcd_data(lcd_data),
	.quiet_state((state == ST_WAIT_START) || (state == ST_IDLE)),
	.cmd_ready(cmd_ready),
	.cmd_valid(cmd_valid),
	.init_done(init_done)
);

// File: test/lcd_tb.sv
module lcd_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import lcd_pkg::*;

	localparam int CLK_PER_US = 2;
	localparam int FIFO_DEPTH = 4;
	localparam int STATUS_POLLS = 1000;
	localparam int INIT_HIGH = INIT_PULSE_US * CLK_PER_US;
	localparam int WRITE_HIGH = E_HIGH_US * CLK_PER_US;		// 26 cycles

	// flags used for the init sequence
	localparam logic CFG_LINES = 1'b1;
	localparam logic CFG_FONT = 1'b0;
	localparam logic CFG_DISP = 1'b1;
	localparam logic CFG_CURSOR = 1'b0;
	localparam logic CFG_BLINK = 1'b1;
	localparam logic CFG_INC = 1'b1;
	localparam logic CFG_SHIFT = 1'b0;
	localparam lcd_cfg_t INIT_CFG = {CFG_LINES, CFG_FONT, CFG_DISP, CFG_CURSOR,
		CFG_BLINK, CFG_INC, CFG_SHIFT};

	logic clk;
	logic rst_n;
	logic psel;
	logic penable;
	logic pwrite;
	apb_addr_t paddr;
	apb_data_t pwdata;
	apb_data_t prdata;
	logic pready;
	logic pslverr;
	logic e;
	logic rs;
	lcd_byte_t lcd_data;

	lcd_cmd_t cap_q[$];		// writes seen on the lcd pins
	int hi_q[$];			// e high time of each write
	lcd_cmd_t exp_q[$];
	lcd_cmd_t held;
	int hi_cycles = 0;
	logic [31:0] lfsr_state;

	lcd_subsys_top #(
		.CLK_PER_US(CLK_PER_US),
		.FIFO_DEPTH(FIFO_DEPTH)
	) UUT (
		.clk(clk),
		.rst_n(rst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.e(e),
		.rs(rs),
		.lcd_data(lcd_data)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// pin monitor, bus is sampled mid-cycle
	always @(negedge clk) begin
		if (!rst_n) begin
			hi_cycles = 0;
		end else if (e) begin
			hi_cycles = hi_cycles + 1;
			held.rs = rs;
			held.data = lcd_data;
		end else if (hi_cycles != 0) begin
			cap_q.push_back(held);		// falling edge of e
			hi_q.push_back(hi_cycles);
			hi_cycles = 0;
		end
	end

	always @(negedge clk) begin
		if (UUT.u_bus.bus_chk.assert_fails != 0) begin
			$display("ERROR at %0t ns: LCD bus protocol assertion failed", $time);
			fail_run();
		end
	end

	task automatic fail_run();
		$display("Errors found");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_byte(input string name, input lcd_byte_t got, input lcd_byte_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
			fail_run();
		end
	endtask

	task automatic check_data(input string name, input apb_data_t got, input apb_data_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
			fail_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s = %b, expected %b", $time, name, got, exp);
			fail_run();
		end
	endtask

	task automatic check_cycles(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("CHECK FAILED at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
			fail_run();
		end
	endtask

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic lcd_byte_t lfsr_byte();
		lcd_byte_t b;
		for (int i = 0; i < 8; i++)
			b[i] = lfsr_bit();
		return b;
	endfunction

	// status layout: busy 0, init_done 1, overflow 2, level 11:8
	function automatic apb_data_t status_word(input logic busy, input logic done,
			input logic ovf, input int lvl);
		apb_data_t w;
		w = '0;
		w[0] = busy;
		w[1] = done;
		w[2] = ovf;
		w[11:8] = lvl[3:0];
		return w;
	endfunction

	task automatic apb_xfer(input logic write, input apb_addr_t addr, input apb_data_t wdata,
			output apb_data_t rdata, output logic err);
		@(posedge clk);
		psel <= 1'b1;		// setup phase
		penable <= 1'b0;
		pwrite <= write;
		paddr <= addr;
		pwdata <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		check_bit("pready", pready, 1'b1);	// no wait states
		rdata = prdata;
		err = pslverr;
		@(posedge clk);		// access ends here
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	task automatic apb_write(input apb_addr_t addr, input apb_data_t wdata, output logic err);
		apb_data_t unused;
		apb_xfer(1'b1, addr, wdata, unused, err);
	endtask

	task automatic apb_read(input apb_addr_t addr, output apb_data_t rdata, output logic err);
		apb_xfer(1'b0, addr, '0, rdata, err);
	endtask

	task automatic push_cmd(input lcd_cmd_t c, output logic err);
		apb_data_t w;
		w = '0;
		w[8] = c.rs;
		w[7:0] = c.data;
		apb_write(REG_CMD, w, err);
	endtask

	task automatic wait_captures(input int n, input int limit);
		int waited;
		waited = 0;
		while (cap_q.size() < n) begin
			@(posedge clk);
			waited++;
			if (waited > limit) begin
				$display("ERROR at %0t ns: only %0d of %0d LCD writes seen",
					$time, cap_q.size(), n);
				fail_run();
			end
		end
	endtask

	task automatic wait_status(input int bit_idx, input logic val, output apb_data_t rd);
		logic err;
		int polls;
		polls = 0;
		apb_read(REG_STATUS, rd, err);
		while (rd[bit_idx] !== val) begin
			polls++;
			if (polls > STATUS_POLLS) begin
				$display("ERROR at %0t ns: status bit %0d never became %b", $time, bit_idx, val);
				fail_run();
			end
			apb_read(REG_STATUS, rd, err);
		end
	endtask

	task automatic check_next_write(input string what, input lcd_cmd_t exp, input int exp_high);
		lcd_cmd_t got;
		int high;
		wait_captures(1, 400);
		got = cap_q.pop_front();
		high = hi_q.pop_front();
		check_bit({what, " rs"}, got.rs, exp.rs);
		check_byte({what, " lcd_data"}, got.data, exp.data);
		check_cycles({what, " e high cycles"}, high, exp_high);
	endtask

	task automatic reset_values();
		apb_data_t rd;
		logic err;
		@(negedge clk);
		check_bit("e", e, 1'b0);
		check_bit("rs", rs, 1'b0);
		check_byte("lcd_data", lcd_data, 8'h00);
		apb_read(REG_STATUS, rd, err);
		check_bit("pslverr", err, 1'b0);
		check_data("status", rd, status_word(1'b1, 1'b0, 1'b0, 0));
	endtask

	task automatic register_decode();
		apb_data_t rd;
		logic err;
		apb_write(REG_CTRL, 32'h0000_0055, err);
		check_bit("pslverr", err, 1'b0);
		apb_read(REG_CTRL, rd, err);
		check_data("ctrl", rd, 32'h0000_0055);
		apb_read(4'hc, rd, err);
		check_bit("pslverr on unmapped read", err, 1'b1);
		apb_write(4'hc, 32'h1234, err);
		check_bit("pslverr on unmapped write", err, 1'b1);
	endtask

	task automatic fifo_overflow();
		lcd_cmd_t c;
		apb_data_t rd;
		logic err;
		exp_q.push_back('{rs: 1'b0, data: 8'h80});	// ddram address 0
		exp_q.push_back('{rs: 1'b1, data: 8'h48});
		exp_q.push_back('{rs: 1'b1, data: 8'h69});
		exp_q.push_back('{rs: 1'b1, data: 8'h21});
		foreach (exp_q[i]) begin
			push_cmd(exp_q[i], err);
			check_bit("pslverr on push", err, 1'b0);
		end
		c = '{rs: 1'b1, data: 8'h3f};
		push_cmd(c, err);
		check_bit("pslverr on full push", err, 1'b1);
		apb_read(REG_STATUS, rd, err);
		check_data("status", rd, status_word(1'b1, 1'b0, 1'b1, 4));
		apb_write(REG_STATUS, '0, err);
		check_bit("pslverr", err, 1'b0);
		apb_read(REG_STATUS, rd, err);
		check_data("status", rd, status_word(1'b1, 1'b0, 1'b0, 4));
	endtask

	task automatic init_sequence();
		lcd_cmd_t exp_init [4];
		apb_data_t rd;
		logic err;
		exp_init[0] = '{rs: 1'b0, data: {4'b0011, CFG_LINES, CFG_FONT, 2'b00}};
		exp_init[1] = '{rs: 1'b0, data: {5'b00001, CFG_DISP, CFG_CURSOR, CFG_BLINK}};
		exp_init[2] = '{rs: 1'b0, data: 8'b0000_0001};
		exp_init[3] = '{rs: 1'b0, data: {6'b000001, CFG_INC, CFG_SHIFT}};
		apb_write(REG_CTRL, apb_data_t'(INIT_CFG) | 32'h100, err);	// start bit
		check_bit("pslverr", err, 1'b0);
		wait_captures(4, 4000);
		for (int i = 0; i < 4; i++)
			check_next_write($sformatf("init instr %0d", i), exp_init[i], INIT_HIGH);
		wait_status(1, 1'b1, rd);
	endtask

	task automatic queued_writes();
		apb_data_t rd;
		for (int i = 0; i < 4; i++)
			check_next_write($sformatf("queued write %0d", i), exp_q.pop_front(), WRITE_HIGH);
		wait_status(0, 1'b0, rd);
		check_data("status", rd, status_word(1'b0, 1'b1, 1'b0, 0));
	endtask

	task automatic random_writes();
		lcd_cmd_t c;
		apb_data_t rd;
		logic err;
		int polls;
		for (int i = 0; i < 12; i++) begin
			polls = 0;
			apb_read(REG_STATUS, rd, err);
			while (rd[11:8] >= 4'(FIFO_DEPTH)) begin	// room for one more
				polls++;
				if (polls > STATUS_POLLS) begin
					$display("ERROR at %0t ns: FIFO never drained", $time);
					fail_run();
				end
				apb_read(REG_STATUS, rd, err);
			end
			c.rs = lfsr_bit();
			c.data = lfsr_byte();
			push_cmd(c, err);
			check_bit("pslverr on push", err, 1'b0);
			exp_q.push_back(c);
		end
		for (int i = 0; i < 12; i++)
			check_next_write($sformatf("random write %0d", i), exp_q.pop_front(), WRITE_HIGH);
		wait_status(0, 1'b0, rd);
		check_data("status", rd, status_word(1'b0, 1'b1, 1'b0, 0));
		check_cycles("extra LCD writes", cap_q.size(), 0);
	endtask

	initial begin
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		lfsr_state = 32'he490;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		reset_values();
		register_decode();
		fifo_overflow();
		init_sequence();
		queued_writes();
		random_writes();
		if (UUT.u_bus.bus_chk.assert_fails == 0) begin
			$display("No errors");
			$finish;
		end else begin
			$display("ERROR: LCD bus protocol assertions failed during the run");
			fail_run();
		end
	end

endmodule
